//--- hw/ex_pkg.sv
`default_nettype none

package ex_pkg;

    parameter int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes
    parameter logic [6:0] OP_IMM    = 7'b0010011;
    parameter logic [6:0] OP_REG    = 7'b0110011;
    parameter logic [6:0] OP_LOAD   = 7'b0000011;
    parameter logic [6:0] OP_STORE  = 7'b0100011;
    parameter logic [6:0] OP_BRANCH = 7'b1100011;
    parameter logic [6:0] OP_JAL    = 7'b1101111;
    parameter logic [6:0] OP_JALR   = 7'b1100111;
    parameter logic [6:0] OP_LUI    = 7'b0110111;
    parameter logic [6:0] OP_AUIPC  = 7'b0010111;

    // funct3 of integer ops
    parameter logic [2:0] F3_ADD_SUB = 3'b000;
    parameter logic [2:0] F3_SLL     = 3'b001;
    parameter logic [2:0] F3_SLT     = 3'b010;
    parameter logic [2:0] F3_SLTU    = 3'b011;
    parameter logic [2:0] F3_XOR     = 3'b100;
    parameter logic [2:0] F3_SR      = 3'b101;
    parameter logic [2:0] F3_OR      = 3'b110;
    parameter logic [2:0] F3_AND     = 3'b111;

    // funct3 of branches, 2 and 3 unused
    parameter logic [2:0] F3_BEQ  = 3'b000;
    parameter logic [2:0] F3_BNE  = 3'b001;
    parameter logic [2:0] F3_BLT  = 3'b100;
    parameter logic [2:0] F3_BGE  = 3'b101;
    parameter logic [2:0] F3_BLTU = 3'b110;
    parameter logic [2:0] F3_BGEU = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;   // bits 31:12 of the value
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } rv_inst_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_ALWAYS
    } br_kind_e;

    typedef struct packed {
        alu_op_e   alu_op;
        word_t     op_a;
        word_t     op_b;
        br_kind_e  br_kind;
        word_t     jump_base;
        word_t     jump_offset;
        logic      reg_w_ena;
        logic      mem_r_ena;
        logic      mem_w_ena;
        reg_addr_t rd;
    } ex_ctrl_t;

    typedef struct packed {
        logic      valid;
        logic      reg_w_ena;
        reg_addr_t rd;
        word_t     reg_w_data;
        logic      mem_r_ena;
        logic      mem_w_ena;
        word_t     mem_addr;
        word_t     mem_w_data;
    } ex_result_t;

    typedef struct packed {
        logic  jump_flag;
        word_t jump_addr;
    } ex_jump_t;

endpackage

`default_nettype wire

//--- hw/ex_decode.sv
`timescale 1ns/1ps
`default_nettype none

module ex_decode (
    input  ex_pkg::rv_inst_u inst_i,
    input  ex_pkg::word_t    pc_i,
    input  ex_pkg::word_t    rs1_data_i,
    input  ex_pkg::word_t    rs2_data_i,
    output ex_pkg::ex_ctrl_t ctrl_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            alt;   // inst bit 30
    ex_pkg::word_t   imm_i;
    ex_pkg::word_t   imm_s;
    ex_pkg::word_t   imm_b;
    ex_pkg::word_t   imm_j;
    ex_pkg::word_t   imm_u;
    ex_pkg::alu_op_e arith_op;

    assign opcode = inst_i.r_fmt.opcode;
    assign funct3 = inst_i.r_fmt.funct3;
    assign alt    = inst_i.r_fmt.funct7[5];

    assign imm_i = {{20{inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};
    assign imm_s = {{20{inst_i.s_fmt.imm_hi[6]}}, inst_i.s_fmt.imm_hi, inst_i.s_fmt.imm_lo};
    assign imm_b = {{20{inst_i.b_fmt.imm_12}}, inst_i.b_fmt.imm_11,
                    inst_i.b_fmt.imm_10_5, inst_i.b_fmt.imm_4_1, 1'b0};
    assign imm_j = {{12{inst_i.j_fmt.imm_20}}, inst_i.j_fmt.imm_19_12,
                    inst_i.j_fmt.imm_11, inst_i.j_fmt.imm_10_1, 1'b0};
    assign imm_u = {inst_i.u_fmt.imm, 12'b0};

    // op-imm and op share this map
    always_comb begin
        case (funct3)
            ex_pkg::F3_ADD_SUB: begin
                // bit 30 is an immediate bit in addi
                if (alt && opcode == ex_pkg::OP_REG) begin
                    arith_op = ex_pkg::ALU_SUB;
                end else begin
                    arith_op = ex_pkg::ALU_ADD;
                end
            end
            ex_pkg::F3_SLL:  arith_op = ex_pkg::ALU_SLL;
            ex_pkg::F3_SLT:  arith_op = ex_pkg::ALU_SLT;
            ex_pkg::F3_SLTU: arith_op = ex_pkg::ALU_SLTU;
            ex_pkg::F3_XOR:  arith_op = ex_pkg::ALU_XOR;
            ex_pkg::F3_SR:   arith_op = alt ? ex_pkg::ALU_SRA : ex_pkg::ALU_SRL;
            ex_pkg::F3_OR:   arith_op = ex_pkg::ALU_OR;
            default:         arith_op = ex_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        ctrl_o = '0;   // alu_op ALU_ADD, br_kind BR_NONE
        case (opcode)
            ex_pkg::OP_IMM, ex_pkg::OP_REG: begin
                ctrl_o.alu_op    = arith_op;
                ctrl_o.op_a      = rs1_data_i;
                ctrl_o.op_b      = (opcode == ex_pkg::OP_REG) ? rs2_data_i : imm_i;
                ctrl_o.reg_w_ena = 1'b1;
                ctrl_o.rd        = inst_i.r_fmt.rd;
            end
            ex_pkg::OP_LOAD: begin
                ctrl_o.op_a      = rs1_data_i;
                ctrl_o.op_b      = imm_i;
                ctrl_o.mem_r_ena = 1'b1;
                ctrl_o.reg_w_ena = 1'b1;
                ctrl_o.rd        = inst_i.i_fmt.rd;
            end
            ex_pkg::OP_STORE: begin
                ctrl_o.op_a      = rs1_data_i;
                ctrl_o.op_b      = imm_s;
                ctrl_o.mem_w_ena = 1'b1;
            end
            ex_pkg::OP_BRANCH: begin
                ctrl_o.jump_base   = pc_i;
                ctrl_o.jump_offset = imm_b;
                case (funct3)
                    ex_pkg::F3_BEQ:  ctrl_o.br_kind = ex_pkg::BR_EQ;
                    ex_pkg::F3_BNE:  ctrl_o.br_kind = ex_pkg::BR_NE;
                    ex_pkg::F3_BLT:  ctrl_o.br_kind = ex_pkg::BR_LT;
                    ex_pkg::F3_BGE:  ctrl_o.br_kind = ex_pkg::BR_GE;
                    ex_pkg::F3_BLTU: ctrl_o.br_kind = ex_pkg::BR_LTU;
                    ex_pkg::F3_BGEU: ctrl_o.br_kind = ex_pkg::BR_GEU;
                    default:         ctrl_o.br_kind = ex_pkg::BR_NONE;
                endcase
            end
            ex_pkg::OP_JAL, ex_pkg::OP_JALR: begin
                ctrl_o.op_a        = pc_i;   // link value pc + 4
                ctrl_o.op_b        = 32'd4;
                ctrl_o.br_kind     = ex_pkg::BR_ALWAYS;
                ctrl_o.jump_base   = (opcode == ex_pkg::OP_JAL) ? pc_i : rs1_data_i;
                ctrl_o.jump_offset = (opcode == ex_pkg::OP_JAL) ? imm_j : imm_i;
                ctrl_o.reg_w_ena   = 1'b1;
                ctrl_o.rd          = inst_i.j_fmt.rd;
            end
            ex_pkg::OP_LUI: begin
                ctrl_o.op_a      = imm_u;
                ctrl_o.reg_w_ena = 1'b1;
                ctrl_o.rd        = inst_i.u_fmt.rd;
            end
            ex_pkg::OP_AUIPC: begin
                ctrl_o.op_a      = pc_i;
                ctrl_o.op_b      = imm_u;
                ctrl_o.reg_w_ena = 1'b1;
                ctrl_o.rd        = inst_i.u_fmt.rd;
            end
            default: begin
                ctrl_o = '0;   // unknown opcode does nothing
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  ex_pkg::ex_ctrl_t ctrl_i,
    output ex_pkg::word_t    result_o
);

    logic [4:0]    shamt;
    ex_pkg::word_t sra_res;
    logic          lt_signed;
    logic          lt_unsigned;

    assign shamt       = ctrl_i.op_b[4:0];
    assign sra_res     = $signed(ctrl_i.op_a) >>> shamt;   // kept apart to stay signed
    assign lt_signed   = $signed(ctrl_i.op_a) < $signed(ctrl_i.op_b);
    assign lt_unsigned = ctrl_i.op_a < ctrl_i.op_b;

    always_comb begin
        case (ctrl_i.alu_op)
            ex_pkg::ALU_ADD:  result_o = ctrl_i.op_a + ctrl_i.op_b;
            ex_pkg::ALU_SUB:  result_o = ctrl_i.op_a - ctrl_i.op_b;
            ex_pkg::ALU_SLL:  result_o = ctrl_i.op_a << shamt;
            ex_pkg::ALU_SLT:  result_o = {31'b0, lt_signed};
            ex_pkg::ALU_SLTU: result_o = {31'b0, lt_unsigned};
            ex_pkg::ALU_XOR:  result_o = ctrl_i.op_a ^ ctrl_i.op_b;
            ex_pkg::ALU_SRL:  result_o = ctrl_i.op_a >> shamt;
            ex_pkg::ALU_SRA:  result_o = sra_res;
            ex_pkg::ALU_OR:   result_o = ctrl_i.op_a | ctrl_i.op_b;
            ex_pkg::ALU_AND:  result_o = ctrl_i.op_a & ctrl_i.op_b;
            default:          result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/ex_branch.sv
`timescale 1ns/1ps
`default_nettype none

module ex_branch (
    input  ex_pkg::ex_ctrl_t ctrl_i,
    input  ex_pkg::word_t    rs1_data_i,
    input  ex_pkg::word_t    rs2_data_i,
    output logic             taken_o,
    output ex_pkg::word_t    target_o
);

    logic equal;
    logic lt_signed;
    logic lt_unsigned;

    assign equal       = rs1_data_i == rs2_data_i;
    assign lt_signed   = $signed(rs1_data_i) < $signed(rs2_data_i);
    assign lt_unsigned = rs1_data_i < rs2_data_i;

    // jalr target keeps bit 0
    assign target_o = ctrl_i.jump_base + ctrl_i.jump_offset;

    always_comb begin
        case (ctrl_i.br_kind)
            ex_pkg::BR_EQ:     taken_o = equal;
            ex_pkg::BR_NE:     taken_o = !equal;
            ex_pkg::BR_LT:     taken_o = lt_signed;
            ex_pkg::BR_GE:     taken_o = !lt_signed;
            ex_pkg::BR_LTU:    taken_o = lt_unsigned;
            ex_pkg::BR_GEU:    taken_o = !lt_unsigned;
            ex_pkg::BR_ALWAYS: taken_o = 1'b1;
            default:           taken_o = 1'b0;   // BR_NONE
        endcase
    end

endmodule

`default_nettype wire

//--- hw/ex_out_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ex_out_reg (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               valid_i,
    input  ex_pkg::ex_ctrl_t   ctrl_i,
    input  ex_pkg::word_t      rs2_data_i,
    input  ex_pkg::word_t      alu_result_i,
    input  logic               taken_i,
    input  ex_pkg::word_t      target_i,
    output ex_pkg::ex_result_t result_o,
    output ex_pkg::ex_jump_t   jump_o
);

    ex_pkg::ex_result_t result_next;
    ex_pkg::ex_jump_t   jump_next;
    logic               mem_access;

    assign mem_access = ctrl_i.mem_r_ena || ctrl_i.mem_w_ena;

    always_comb begin
        result_next.valid      = 1'b1;
        result_next.reg_w_ena  = ctrl_i.reg_w_ena;
        result_next.rd         = ctrl_i.rd;
        // load data arrives in the memory stage
        result_next.reg_w_data = (ctrl_i.reg_w_ena && !ctrl_i.mem_r_ena) ? alu_result_i : '0;
        result_next.mem_r_ena  = ctrl_i.mem_r_ena;
        result_next.mem_w_ena  = ctrl_i.mem_w_ena;
        result_next.mem_addr   = mem_access ? alu_result_i : '0;
        result_next.mem_w_data = ctrl_i.mem_w_ena ? rs2_data_i : '0;

        jump_next.jump_flag = taken_i;
        jump_next.jump_addr = taken_i ? target_i : '0;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            result_o <= '0;
            jump_o   <= '0;
        end else if (valid_i) begin
            result_o <= result_next;
            jump_o   <= jump_next;
        end else begin
            result_o <= '0;   // bubble
            jump_o   <= '0;
        end
    end

endmodule

`default_nettype wire

//--- hw/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               valid_i,
    input  ex_pkg::rv_inst_u   inst_i,
    input  ex_pkg::word_t      pc_i,
    input  ex_pkg::word_t      rs1_data_i,
    input  ex_pkg::word_t      rs2_data_i,
    output ex_pkg::ex_result_t result_o,
    output ex_pkg::ex_jump_t   jump_o
);

    ex_pkg::ex_ctrl_t ctrl;
    ex_pkg::word_t    alu_result;
    logic             taken;
    ex_pkg::word_t    target;

    ex_decode decode_inst (
        .inst_i     (inst_i),
        .pc_i       (pc_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .ctrl_o     (ctrl)
    );

    ex_alu alu_inst (
        .ctrl_i   (ctrl),
        .result_o (alu_result)
    );

    ex_branch branch_inst (
        .ctrl_i     (ctrl),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .taken_o    (taken),
        .target_o   (target)
    );

    // only state in the stage
    ex_out_reg out_reg_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .valid_i      (valid_i),
        .ctrl_i       (ctrl),
        .rs2_data_i   (rs2_data_i),
        .alu_result_i (alu_result),
        .taken_i      (taken),
        .target_i     (target),
        .result_o     (result_o),
        .jump_o       (jump_o)
    );

endmodule

`default_nettype wire

//--- include/ex_ref_model.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// integer result for a funct3, with sub and sra picked by the caller
function automatic ex_pkg::word_t ref_alu(input logic [2:0] f3, input logic sub,
                                          input logic sra, input ex_pkg::word_t a,
                                          input ex_pkg::word_t b);
    ex_pkg::word_t sra_val;
    sra_val = $signed(a) >>> b[4:0];
    case (f3)
        ex_pkg::F3_ADD_SUB: return sub ? a - b : a + b;
        ex_pkg::F3_SLL:     return a << b[4:0];
        ex_pkg::F3_SLT:     return {31'b0, $signed(a) < $signed(b)};
        ex_pkg::F3_SLTU:    return {31'b0, a < b};
        ex_pkg::F3_XOR:     return a ^ b;
        ex_pkg::F3_SR:      return sra ? sra_val : a >> b[4:0];
        ex_pkg::F3_OR:      return a | b;
        default:            return a & b;
    endcase
endfunction

// expected outputs one cycle after a valid instruction
function automatic void ref_predict(input ex_pkg::word_t inst, input ex_pkg::word_t pc,
                                    input ex_pkg::word_t rs1, input ex_pkg::word_t rs2,
                                    output ex_pkg::ex_result_t res,
                                    output ex_pkg::ex_jump_t jmp);
    ex_pkg::word_t imm_i;
    ex_pkg::word_t imm_s;
    ex_pkg::word_t imm_b;
    ex_pkg::word_t imm_j;
    ex_pkg::word_t imm_u;
    logic [2:0]    f3;
    logic          cond;
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    imm_u = {inst[31:12], 12'b0};
    f3 = inst[14:12];
    cond = 1'b0;
    res = '0;
    jmp = '0;
    res.valid = 1'b1;
    case (inst[6:0])
        ex_pkg::OP_IMM, ex_pkg::OP_REG: begin
            res.reg_w_ena = 1'b1;
            res.rd = inst[11:7];
            if (inst[6:0] == ex_pkg::OP_REG) begin
                res.reg_w_data = ref_alu(f3, inst[30], inst[30], rs1, rs2);
            end else begin
                res.reg_w_data = ref_alu(f3, 1'b0, inst[30], rs1, imm_i);
            end
        end
        ex_pkg::OP_LOAD: begin
            res.reg_w_ena = 1'b1;
            res.rd = inst[11:7];
            res.mem_r_ena = 1'b1;
            res.mem_addr = rs1 + imm_i;
        end
        ex_pkg::OP_STORE: begin
            res.mem_w_ena = 1'b1;
            res.mem_addr = rs1 + imm_s;
            res.mem_w_data = rs2;
        end
        ex_pkg::OP_BRANCH: begin
            case (f3)
                ex_pkg::F3_BEQ:  cond = rs1 == rs2;
                ex_pkg::F3_BNE:  cond = rs1 != rs2;
                ex_pkg::F3_BLT:  cond = $signed(rs1) < $signed(rs2);
                ex_pkg::F3_BGE:  cond = $signed(rs1) >= $signed(rs2);
                ex_pkg::F3_BLTU: cond = rs1 < rs2;
                ex_pkg::F3_BGEU: cond = rs1 >= rs2;
                default:         cond = 1'b0;
            endcase
            jmp.jump_flag = cond;
            jmp.jump_addr = cond ? pc + imm_b : '0;
        end
        ex_pkg::OP_JAL, ex_pkg::OP_JALR: begin
            res.reg_w_ena = 1'b1;
            res.rd = inst[11:7];
            res.reg_w_data = pc + 32'd4;
            jmp.jump_flag = 1'b1;
            jmp.jump_addr = (inst[6:0] == ex_pkg::OP_JAL) ? pc + imm_j : rs1 + imm_i;
        end
        ex_pkg::OP_LUI, ex_pkg::OP_AUIPC: begin
            res.reg_w_ena = 1'b1;
            res.rd = inst[11:7];
            res.reg_w_data = (inst[6:0] == ex_pkg::OP_LUI) ? imm_u : pc + imm_u;
        end
        default: begin
            res.valid = 1'b1;   // unknown opcode, all else zero
        end
    endcase
endfunction

`endif

//--- test/tb_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;

    `include "ex_ref_model.svh"

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_VECTORS  = 170;   // steps issued by all tests

    logic               clk;
    logic               reset_i;
    logic               valid_i;
    ex_pkg::rv_inst_u   inst_i;
    ex_pkg::word_t      pc_i;
    ex_pkg::word_t      rs1_data_i;
    ex_pkg::word_t      rs2_data_i;
    ex_pkg::ex_result_t result_o;
    ex_pkg::ex_jump_t   jump_o;

    ex_pkg::ex_result_t exp_res_q [$];
    ex_pkg::ex_jump_t   exp_jmp_q [$];
    logic [31:0]        rng_state = 32'd29270;
    string              test_name;
    int                 errors;
    int                 checks;
    int                 errors_before;
    int                 checks_before;
    int                 tests_run;
    int                 tests_failed;

    ex_stage ex_stage_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .valid_i    (valid_i),
        .inst_i     (inst_i),
        .pc_i       (pc_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .result_o   (result_o),
        .jump_o     (jump_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic ex_pkg::word_t next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // instruction words, register fields x1 and x2 where unused
    function automatic ex_pkg::word_t r_word(input logic [6:0] f7, input logic [2:0] f3,
                                             input ex_pkg::reg_addr_t rd);
        return {f7, 5'd2, 5'd1, f3, rd, ex_pkg::OP_REG};
    endfunction

    function automatic ex_pkg::word_t i_word(input logic [11:0] imm, input logic [2:0] f3,
                                             input ex_pkg::reg_addr_t rd,
                                             input logic [6:0] op);
        return {imm, 5'd1, f3, rd, op};
    endfunction

    function automatic ex_pkg::word_t s_word(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], ex_pkg::OP_STORE};
    endfunction

    function automatic ex_pkg::word_t b_word(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], ex_pkg::OP_BRANCH};
    endfunction

    function automatic ex_pkg::word_t u_word(input logic [19:0] imm,
                                             input ex_pkg::reg_addr_t rd,
                                             input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic ex_pkg::word_t j_word(input logic [20:0] imm,
                                             input ex_pkg::reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, ex_pkg::OP_JAL};
    endfunction

    task automatic check_result(input ex_pkg::ex_result_t got, input ex_pkg::ex_result_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0d ns: %s result_o is %h, expected %h",
                     $time, test_name, got, exp);
        end
    endtask

    task automatic check_jump(input ex_pkg::ex_jump_t got, input ex_pkg::ex_jump_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0d ns: %s jump_o is %h, expected %h",
                     $time, test_name, got, exp);
        end
    endtask

    // one cycle: drive, then check the instruction of the cycle before
    task automatic step(input logic valid, input ex_pkg::word_t inst, input ex_pkg::word_t pc,
                        input ex_pkg::word_t rs1, input ex_pkg::word_t rs2);
        ex_pkg::ex_result_t res;
        ex_pkg::ex_jump_t   jmp;
        @(posedge clk);
        valid_i    <= valid;
        inst_i     <= inst;
        pc_i       <= pc;
        rs1_data_i <= rs1;
        rs2_data_i <= rs2;
        if (valid) begin
            ref_predict(inst, pc, rs1, rs2, res, jmp);
        end else begin
            res = '0;   // bubble
            jmp = '0;
        end
        exp_res_q.push_back(res);
        exp_jmp_q.push_back(jmp);
        @(negedge clk);
        if (exp_res_q.size() > 1) begin
            check_result(result_o, exp_res_q.pop_front());
            check_jump(jump_o, exp_jmp_q.pop_front());
        end
    endtask

    task automatic issue(input ex_pkg::word_t inst, input ex_pkg::word_t pc,
                         input ex_pkg::word_t rs1, input ex_pkg::word_t rs2);
        step(1'b1, inst, pc, rs1, rs2);
    endtask

    task automatic bubble();
        step(1'b0, next_rand(), next_rand(), next_rand(), next_rand());   // junk on the inputs
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        errors_before = errors;
        checks_before = checks;
    endtask

    task automatic end_test();
        bubble();   // flushes the last instruction
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
        end
        $display("test %-7s done: %0d checks, %0d errors", test_name,
                 checks - checks_before, errors - errors_before);
    endtask

    task automatic test_reset_idle();
        begin_test("reset");
        @(negedge clk);
        check_result(result_o, '0);
        check_jump(jump_o, '0);
        issue(i_word(12'h123, ex_pkg::F3_ADD_SUB, 5'd3, ex_pkg::OP_IMM), 32'h100, next_rand(),
              32'h0);
        bubble();
        bubble();
        end_test();
    endtask

    task automatic test_r_type();
        logic [2:0]    f3;
        logic          alt;
        ex_pkg::word_t a;
        ex_pkg::word_t pair_a [4];
        ex_pkg::word_t pair_b [4];
        begin_test("r_type");
        for (int k = 0; k < 10; k++) begin
            f3  = (k < 8) ? 3'(k) : ((k == 8) ? ex_pkg::F3_ADD_SUB : ex_pkg::F3_SR);
            alt = (k >= 8);   // sub and sra
            for (int n = 0; n < 4; n++) begin
                issue(r_word({1'b0, alt, 5'b0}, f3, 5'(next_rand())), next_rand(),
                      next_rand(), next_rand());
            end
        end
        for (int n = 0; n < 2; n++) begin
            a = next_rand();
            issue(r_word(7'h00, ex_pkg::F3_SLL, 5'd5), 32'h0, a, (n == 0) ? 32'd0 : 32'd31);
            issue(r_word(7'h00, ex_pkg::F3_SR, 5'd5), 32'h0, a, (n == 0) ? 32'd0 : 32'd31);
            issue(r_word(7'h20, ex_pkg::F3_SR, 5'd5), 32'h0, a, (n == 0) ? 32'd0 : 32'd31);
        end
        pair_a = '{32'h8000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0005};
        pair_b = '{32'h7fff_ffff, 32'h8000_0000, 32'h0000_0000, 32'h0000_0005};
        for (int n = 0; n < 4; n++) begin
            issue(r_word(7'h00, ex_pkg::F3_SLT, 5'd6), 32'h0, pair_a[n], pair_b[n]);
            issue(r_word(7'h00, ex_pkg::F3_SLTU, 5'd6), 32'h0, pair_a[n], pair_b[n]);
        end
        end_test();
    endtask

    task automatic test_i_type();
        logic [2:0]    f3;
        logic [11:0]   imm;
        ex_pkg::word_t r;
        begin_test("i_type");
        for (int k = 0; k < 9; k++) begin
            f3 = (k < 8) ? 3'(k) : ex_pkg::F3_SR;
            for (int n = 0; n < 4; n++) begin
                r   = next_rand();
                imm = r[11:0];
                if (f3 == ex_pkg::F3_SLL || f3 == ex_pkg::F3_SR) begin
                    imm = {1'b0, k == 8, 5'b0, r[4:0]};   // k == 8 gives srai
                end
                issue(i_word(imm, f3, r[11:7], ex_pkg::OP_IMM), 32'h0, next_rand(), 32'h0);
            end
        end
        issue(i_word(12'hfff, ex_pkg::F3_ADD_SUB, 5'd7, ex_pkg::OP_IMM), 32'h0, 32'h0, 32'h0);
        issue(i_word(12'h800, ex_pkg::F3_SLT, 5'd7, ex_pkg::OP_IMM), 32'h0, 32'h0, 32'h0);
        issue(i_word(12'hfff, ex_pkg::F3_SLTU, 5'd7, ex_pkg::OP_IMM), 32'h0, 32'hffff_fffe,
              32'h0);
        end_test();
    endtask

    task automatic test_branch();
        logic [2:0]    f3;
        logic [12:0]   off;
        ex_pkg::word_t a;
        ex_pkg::word_t b;
        begin_test("branch");
        for (int k = 0; k < 8; k++) begin
            f3 = 3'(k);
            if (f3[2:1] != 2'b01) begin
                for (int n = 0; n < 5; n++) begin
                    a = next_rand();
                    b = next_rand();
                    case (n)
                        0: b = a;
                        1: begin
                            a[31] = 1'b1;   // negative against positive
                            b[31] = 1'b0;
                        end
                        2: begin
                            a[31] = 1'b0;
                            b[31] = 1'b1;
                        end
                        default: ;
                    endcase
                    off = 13'(next_rand()) & 13'h1ffe;
                    issue(b_word(off, f3), next_rand() & 32'hffff_fffc, a, b);
                end
            end
        end
        for (int n = 0; n < 4; n++) begin
            a = next_rand();
            issue(j_word(21'(a) & 21'h1ffffe, a[11:7]), next_rand() & 32'hffff_fffc,
                  next_rand(), 32'h0);
            issue(i_word(a[31:20], 3'b000, a[11:7], ex_pkg::OP_JALR),
                  next_rand() & 32'hffff_fffc, next_rand(), 32'h0);
        end
        end_test();
    endtask

    task automatic test_mem();
        ex_pkg::word_t r;
        begin_test("mem");
        for (int n = 0; n < 6; n++) begin
            r = next_rand();
            issue(i_word(r[31:20], 3'(n % 3), r[11:7], ex_pkg::OP_LOAD), 32'h0, next_rand(),
                  next_rand());
            issue(s_word(r[31:20], 3'(n % 3)), 32'h0, next_rand(), next_rand());
        end
        end_test();
    endtask

    task automatic test_upper_misc();
        ex_pkg::word_t r;
        begin_test("misc");
        for (int n = 0; n < 3; n++) begin
            r = next_rand();
            issue(u_word(r[31:12], r[11:7], ex_pkg::OP_LUI), next_rand(), next_rand(),
                  next_rand());
            issue(u_word(r[31:12], r[11:7], ex_pkg::OP_AUIPC), next_rand(), next_rand(),
                  next_rand());
        end
        issue(32'hffff_ffff, 32'h200, next_rand(), next_rand());   // opcode 7f
        issue({25'(next_rand()), 7'b0001011}, 32'h200, next_rand(), next_rand());
        issue(b_word(13'h0010, 3'd2), 32'h100, 32'd5, 32'd5);
        issue(b_word(13'h0010, 3'd3), 32'h100, 32'd5, 32'd5);
        for (int n = 0; n < 4; n++) begin
            r = next_rand();
            issue(r_word({1'b0, r[30], 5'b0}, r[14:12], r[11:7]), 32'h0, next_rand(),
                  next_rand());
            issue(b_word(r[12:0] & 13'h1ffe, ex_pkg::F3_BNE), r & 32'hffff_fffc, next_rand(),
                  next_rand());
        end
        end_test();
    endtask

    initial begin
        #((2 * NUM_VECTORS + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout: the tests did not finish in %0d ns",
                 (2 * NUM_VECTORS + RESET_CYCLES) * CLK_PERIOD);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        reset_i    = 1'b1;
        valid_i    = 1'b0;
        inst_i     = '0;
        pc_i       = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
        test_reset_idle();
        test_r_type();
        test_i_type();
        test_branch();
        test_mem();
        test_upper_misc();
        $display("tests run %0d, tests with errors %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
hw/ex_pkg.sv
hw/ex_decode.sv
hw/ex_alu.sv
hw/ex_branch.sv
hw/ex_out_reg.sv
hw/ex_stage.sv
test/tb_ex_stage.sv

//--- run_sim.sh
#!/bin/sh
# builds the execute stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f compile.f \
    --top-module tb_ex_stage -o tb_ex_stage
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_ex_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
    exit 0
fi
exit 1
